// ==== Makefile ====
TOP = tb_uartMsgTop

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== btnDebounce.sv ====
// Button synchronizer, stability counter and re-arm flag giving one play pulse per press
`include "uart_consts.svh"

module btnDebounce (
    input  logic sys_clk,
    input  logic rstN,
    input  logic btn,
    output logic playReq
);
    localparam int cntW = $clog2(`DEBOUNCE_CYCLES);
    localparam logic [cntW-1:0] stableLast = cntW'(`DEBOUNCE_CYCLES - 1);

    logic [1:0]      syncReg;
    logic            btnSync;
    logic            btnStable;                // Debounced level, low is pressed
    logic [cntW-1:0] stableCnt;
    logic            armed;                    // Set after a stable release

    assign btnSync = syncReg[1];

    always_ff @(posedge sys_clk) begin
        if (!rstN) begin
            syncReg   <= 2'b11;                // Released
            btnStable <= 1'b1;
            stableCnt <= '0;
            armed     <= 1'b1;
            playReq   <= 1'b0;
        end else begin
            syncReg <= {syncReg[0], btn};
            playReq <= 1'b0;
            if (btnSync != btnStable) begin
                if (stableCnt == stableLast) begin
                    btnStable <= btnSync;      // New level accepted
                    stableCnt <= '0;
                    if (btnSync) begin
                        armed <= 1'b1;         // Stable release
                    end else if (armed) begin
                        playReq <= 1'b1;       // One pulse per press
                        armed   <= 1'b0;
                    end
                end else begin
                    stableCnt <= stableCnt + 1'b1;
                end
            end else begin
                stableCnt <= '0;               // Bounce restarts the count
            end
        end
    end

endmodule

// ==== msgBuffer.sv ====
// Message memory with record, clear and overflow rules, status LEDs and credit-paced playback
`include "uart_consts.svh"

module msgBuffer #(
    parameter int depth = 8                    // Byte slots
) (
    input  logic                sys_clk,
    input  logic                rstN,
    input  uartPkg::byteBeat_t  rxBeat,
    input  logic                playReq,
    input  logic                creditReturn,
    output uartPkg::byteBeat_t  txBeat,
    output uartPkg::statusLed_t status
);
    import uartPkg::*;

    localparam int cntW = $clog2(depth + 1);   // Count runs 0 to depth
    localparam int ptrW = $clog2(depth);

    logic [7:0]      mem [depth];
    logic [cntW-1:0] msgCount;                 // Stored bytes
    logic [ptrW-1:0] rdPtr;                    // Next slot to play
    logic            playing;
    logic [1:0]      creditCnt;                // Transmitter credits held
    statusLed_t      statusReg;

    logic            issue;
    logic            lastByte;
    logic            startPlay;
    logic            rxAccept;
    logic            isClear;
    logic            hasRoom;
    logic            storeByte;

    assign issue     = playing && (creditCnt != 2'd0);        // One beat per credit
    assign lastByte  = (cntW'(rdPtr) + cntW'(1)) == msgCount;
    assign startPlay = !playing && playReq && (msgCount != '0);
    assign rxAccept  = !playing && !startPlay && rxBeat.valid; // Dropped while playing
    assign isClear   = (rxBeat.data == `CLEAR_CODE);
    assign hasRoom   = (msgCount < cntW'(depth));
    assign storeByte = rxAccept && !isClear && hasRoom;

    assign txBeat = byteBeat_t'{valid: issue, data: mem[rdPtr]};
    assign status = statusReg;

    always_ff @(posedge sys_clk) begin
        if (!rstN) begin
            msgCount  <= '0;
            rdPtr     <= '0;
            playing   <= 1'b0;
            creditCnt <= 2'd1;                 // Transmitter starts empty
            statusReg <= '{led: 4'h0, rgb: `RGB_IDLE};
        end else begin
            creditCnt <= creditCnt + 2'(creditReturn) - 2'(issue);

            if (playing) begin
                if (issue) begin
                    rdPtr <= rdPtr + 1'b1;
                    if (lastByte) begin
                        playing <= 1'b0;       // Last stored byte issued
                    end
                end
            end else if (startPlay) begin
                playing <= 1'b1;
                rdPtr   <= '0;
            end

            if (rxAccept) begin
                statusReg.led <= rxBeat.data[3:0];
                if (isClear) begin
                    msgCount      <= '0;       // Contents left in place
                    statusReg.rgb <= `RGB_CLEARED;
                end else if (hasRoom) begin
                    msgCount      <= msgCount + 1'b1;
                    statusReg.rgb <= `RGB_STORED;
                end else begin
                    statusReg.rgb <= `RGB_FULL;  // Overflow byte dropped
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (storeByte) begin
            mem[msgCount[ptrW-1:0]] <= rxBeat.data;
        end
    end

endmodule

// ==== tb.f ====
+incdir+.
uartPkg.sv
uartRx.sv
uartTx.sv
msgBuffer.sv
btnDebounce.sv
uartMsgTop.sv
tb_uartMsgTop.sv

// ==== tb_uartMsgTop.sv ====
// Random self-checking testbench with serial driver, tx monitor and buffer reference model
`include "uart_consts.svh"

module tb_uartMsgTop;
    import uartPkg::*;

    localparam int frameCycles = 10 * `CLKS_PER_BIT;             // One UART frame
    localparam int nRand       = 5;                              // Bytes in first recording
    localparam int nOver       = `MSG_DEPTH + 2;                 // Two past full
    localparam int numFrames   = 1 + nRand + 2 * (nRand + 2) + 1 + 2 + nOver
                                 + 3 * (`MSG_DEPTH + 2);         // Sent, played and held
    localparam int cycleLimit  = numFrames * frameCycles * 2 + 12 * `DEBOUNCE_CYCLES + 500;

    logic       sys_clk;
    logic       rstN;
    logic       rx;
    logic       btn;
    logic       tx;
    statusLed_t status;

    logic [31:0] lcgState = 32'hcee9_0ac8;
    int          errCount = 0;
    int          cycleCnt = 0;
    logic [7:0]  modelMem [$];                 // Bytes the buffer should hold
    logic [3:0]  expLed   = 4'h0;
    logic [2:0]  expRgb   = `RGB_IDLE;
    logic [7:0]  gotQ [$];                     // Bytes decoded from tx

    uartMsgTop UUT (
        .sys_clk (sys_clk),
        .rstN    (rstN),
        .rx      (rx),
        .btn     (btn),
        .tx      (tx),
        .status  (status)
    );

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [7:0] randByte();
        logic [31:0] r;
        r = nextRand();
        return (r[23:16] == `CLEAR_CODE) ? 8'h5A : r[23:16];    // Clear only sent on purpose
    endfunction

    task automatic checkValue(input string sigName, input logic [31:0] expV,
                              input logic [31:0] gotV);
        assert (gotV === expV) else begin
            $display("CHECK FAILED time=%0t %s expected=%0h actual=%0h",
                     $time, sigName, expV, gotV);
            errCount++;
        end
    endtask

    // Buffer rules for one received byte
    function automatic void modelRx(input logic [7:0] b);
        expLed = b[3:0];
        if (b == `CLEAR_CODE) begin
            modelMem.delete();
            expRgb = `RGB_CLEARED;
        end else if (modelMem.size() < `MSG_DEPTH) begin
            modelMem.push_back(b);
            expRgb = `RGB_STORED;
        end else begin
            expRgb = `RGB_FULL;                // Overflow dropped
        end
    endfunction

    // Start bit, 8 data bits LSB first and stop bit
    task automatic sendByte(input logic [7:0] b, input bit ignored);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge sys_clk);
            rx <= frame[i];
            repeat (`CLKS_PER_BIT - 1) @(posedge sys_clk);
        end
        if (!ignored) begin
            modelRx(b);                        // Ignored bytes leave the model alone
        end
        @(negedge sys_clk);                    // Beat came mid stop bit
        checkValue("status.led", 32'(expLed), 32'(status.led));
        checkValue("status.rgb", 32'(expRgb), 32'(status.rgb));
    endtask

    task automatic sendRandom(input int n);
        for (int i = 0; i < n; i++) begin
            sendByte(randByte(), 1'b0);
            repeat (nextRand() % 16) @(posedge sys_clk);   // Random idle gap
        end
    endtask

    // Press and hold past the playback, then release and compare
    task automatic playCheck();
        int expCount;
        expCount = modelMem.size();
        gotQ.delete();
        @(posedge sys_clk);
        btn <= 1'b0;
        while (gotQ.size() < expCount) @(posedge sys_clk);
        repeat (2 * frameCycles) @(posedge sys_clk);       // Button still held so no replay
        btn <= 1'b1;
        repeat (`DEBOUNCE_CYCLES + 8) @(posedge sys_clk);  // Stable release re-arms
        checkValue("tx frame count", 32'(expCount), 32'(gotQ.size()));
        for (int i = 0; i < expCount && i < gotQ.size(); i++) begin
            checkValue("tx byte", 32'(modelMem[i]), 32'(gotQ[i]));
        end
    endtask

    task automatic finishRun();
        $display("Errors: %0d", errCount);
        if (errCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    // Serial monitor decoding tx frames mid-bit
    initial begin
        logic [7:0] data;
        forever begin
            @(negedge sys_clk);
            if (rstN && tx === 1'b0) begin
                repeat (`CLKS_PER_BIT / 2 - 1) @(negedge sys_clk);
                checkValue("tx start bit", 32'(1'b0), 32'(tx));
                for (int i = 0; i < 8; i++) begin
                    repeat (`CLKS_PER_BIT) @(negedge sys_clk);
                    data[i] = tx;
                end
                repeat (`CLKS_PER_BIT) @(negedge sys_clk);
                checkValue("tx stop bit", 32'(1'b1), 32'(tx));
                gotQ.push_back(data);
            end
        end
    end

    // Watchdog
    initial begin
        while (cycleCnt < cycleLimit) begin
            @(posedge sys_clk);
            cycleCnt++;
        end
        $display("ERROR: timeout after %0d cycles, test sequence did not complete", cycleCnt);
        errCount++;
        finishRun();
    end

    initial begin
        rstN <= 1'b0;
        rx   <= 1'b1;                          // Idle line
        btn  <= 1'b1;                          // Released
        repeat (4) @(posedge sys_clk);
        rstN <= 1'b1;

        // Quiet after reset
        for (int i = 0; i < frameCycles; i++) begin
            @(negedge sys_clk);
            checkValue("tx", 32'(1'b1), 32'(tx));
            checkValue("status", 32'(0), 32'(status));
        end

        sendRandom(nRand);                     // Record
        playCheck();                           // Held press gives one playback
        playCheck();                           // New press gives the same sequence

        sendByte(`CLEAR_CODE, 1'b0);
        playCheck();                           // Empty buffer sends no frames

        sendRandom(nOver);                     // Last two hit a full buffer
        playCheck();

        // rx traffic while playing is dropped
        fork
            playCheck();
            begin
                repeat (60) @(posedge sys_clk);
                for (int k = 0; k < 3; k++) begin
                    sendByte(8'(nextRand() >> 24), 1'b1);
                end
            end
        join
        playCheck();                           // Unchanged replay

        finishRun();
    end

endmodule

// ==== uartMsgTop.sv ====
// Top level wiring of UART receiver, button debouncer, message buffer and UART transmitter
`include "uart_consts.svh"

module uartMsgTop (
    input  logic                sys_clk,
    input  logic                rstN,
    input  logic                rx,
    input  logic                btn,
    output logic                tx,
    output uartPkg::statusLed_t status
);
    import uartPkg::*;

    byteBeat_t rxBeat;                         // Receiver to buffer
    byteBeat_t txBeat;                         // Buffer to transmitter
    logic      playReq;
    logic      creditReturn;

    uartRx #(
        .clksPerBit (`CLKS_PER_BIT)
    ) uRx (
        .sys_clk (sys_clk),
        .rstN    (rstN),
        .rx      (rx),
        .rxBeat  (rxBeat)
    );

    btnDebounce uBtn (
        .sys_clk (sys_clk),
        .rstN    (rstN),
        .btn     (btn),
        .playReq (playReq)
    );

    msgBuffer #(
        .depth (`MSG_DEPTH)
    ) uBuf (
        .sys_clk      (sys_clk),
        .rstN         (rstN),
        .rxBeat       (rxBeat),
        .playReq      (playReq),
        .creditReturn (creditReturn),
        .txBeat       (txBeat),
        .status       (status)
    );

    uartTx #(
        .clksPerBit (`CLKS_PER_BIT)
    ) uTx (
        .sys_clk      (sys_clk),
        .rstN         (rstN),
        .txBeat       (txBeat),
        .tx           (tx),
        .creditReturn (creditReturn)
    );

endmodule

// ==== uartPkg.sv ====
// Packed structs for byte beats and board status outputs
package uartPkg;

    // One byte on a receive or transmit path
    typedef struct packed {
        logic       valid;     // High for one cycle per byte
        logic [7:0] data;      // Byte payload
    } byteBeat_t;

    // Board LED outputs
    typedef struct packed {
        logic [3:0] led;       // Low nibble of last received byte
        logic [2:0] rgb;       // Buffer state code
    } statusLed_t;

endpackage

// ==== uartRx.sv ====
// UART receiver with input synchronizer, mid-bit sampling FSM and byte beat output
module uartRx #(
    parameter int clksPerBit = 16              // System clocks per serial bit
) (
    input  logic               sys_clk,
    input  logic               rstN,
    input  logic               rx,
    output uartPkg::byteBeat_t rxBeat
);
    localparam int cntW = $clog2(clksPerBit);
    localparam logic [cntW-1:0] halfLast = cntW'(clksPerBit / 2 - 1);  // Half bit from edge
    localparam logic [cntW-1:0] waitLast = cntW'(clksPerBit - 2);      // Full bit incl. read cycle

    typedef enum logic [2:0] {
        sIdle,
        sStart,
        sWait,
        sRead,
        sStop
    } rxState_t;

    rxState_t        state;
    logic [2:0]      syncReg;                  // Two sync flops plus edge history
    logic            rxSync;
    logic            fallEdge;
    logic [cntW-1:0] bitCnt;                   // Clocks within current bit
    logic [2:0]      bitIdx;                   // Data bit number
    logic [7:0]      shiftReg;                 // Fills from the MSB end
    logic            beatValid;

    assign rxSync   = syncReg[1];
    assign fallEdge = syncReg[2] & ~syncReg[1];     // High to low on the line
    assign rxBeat   = '{valid: beatValid, data: shiftReg};

    always_ff @(posedge sys_clk) begin
        if (!rstN) begin
            syncReg <= '1;                     // Line idles high
        end else begin
            syncReg <= {syncReg[1:0], rx};
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rstN) begin
            state     <= sIdle;
            bitCnt    <= '0;
            bitIdx    <= '0;
            beatValid <= 1'b0;
        end else begin
            beatValid <= 1'b0;                 // Single-cycle beat
            case (state)
                sIdle: begin
                    if (fallEdge) begin        // Start of frame
                        state  <= sStart;
                        bitCnt <= '0;
                        bitIdx <= '0;
                    end
                end
                sStart: begin
                    if (bitCnt == halfLast) begin
                        bitCnt <= '0;
                        state  <= rxSync ? sIdle : sWait;   // Glitch returns to idle
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                sWait: begin
                    if (bitCnt == waitLast) begin
                        state <= sRead;        // Next cycle is mid-bit
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                sRead: begin
                    bitCnt <= '0;
                    bitIdx <= bitIdx + 1'b1;
                    state  <= (bitIdx == 3'd7) ? sStop : sWait;
                end
                sStop: begin
                    if (bitCnt == waitLast) begin
                        state     <= sIdle;    // Stop level not checked
                        beatValid <= 1'b1;     // Mid stop bit
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                default: state <= sIdle;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge sys_clk) begin
        if (state == sRead) begin
            shiftReg <= {rxSync, shiftReg[7:1]};
        end
    end

endmodule

// ==== uartTx.sv ====
// UART transmitter with byte latch, bit shifter, registered line output and credit return
module uartTx #(
    parameter int clksPerBit = 16              // System clocks per serial bit
) (
    input  logic               sys_clk,
    input  logic               rstN,
    input  uartPkg::byteBeat_t txBeat,
    output logic               tx,
    output logic               creditReturn
);
    localparam int cntW = $clog2(clksPerBit);
    localparam logic [cntW-1:0] bitLast = cntW'(clksPerBit - 1);

    typedef enum logic [1:0] {
        sIdle,
        sStart,
        sData,
        sStop
    } txState_t;

    txState_t        state;
    logic [cntW-1:0] bitCnt;                   // Clocks within current bit
    logic [2:0]      bitIdx;                   // Data bit number
    logic [7:0]      shiftReg;                 // Current bit at position 0
    logic            txReg;
    logic            bitEnd;

    assign bitEnd       = (bitCnt == bitLast);
    assign tx           = txReg;
    assign creditReturn = (state == sStop) && bitEnd;   // Last stop-bit cycle

    always_ff @(posedge sys_clk) begin
        if (!rstN) begin
            state  <= sIdle;
            bitCnt <= '0;
            bitIdx <= '0;
            txReg  <= 1'b1;                    // Idle line high
        end else begin
            case (state)
                sIdle: begin
                    if (txBeat.valid) begin
                        state  <= sStart;
                        bitCnt <= '0;
                        txReg  <= 1'b0;        // Start bit next cycle
                    end
                end
                sStart: begin
                    if (bitEnd) begin
                        state  <= sData;
                        bitCnt <= '0;
                        bitIdx <= '0;
                        txReg  <= shiftReg[0];
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                sData: begin
                    if (bitEnd) begin
                        bitCnt <= '0;
                        if (bitIdx == 3'd7) begin
                            state <= sStop;
                            txReg <= 1'b1;     // Stop bit
                        end else begin
                            bitIdx <= bitIdx + 1'b1;
                            txReg  <= shiftReg[1];
                        end
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                sStop: begin
                    if (bitEnd) begin
                        state  <= sIdle;
                        bitCnt <= '0;
                    end else begin
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                default: state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == sIdle && txBeat.valid) begin
            shiftReg <= txBeat.data;           // Latch on accept
        end else if (state == sData && bitEnd) begin
            shiftReg <= shiftReg >> 1;         // LSB first
        end
    end

endmodule

// ==== uart_consts.svh ====
// Bit timing, buffer depth, clear command, debounce length and RGB status codes
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Serial bit timing
`define CLKS_PER_BIT     16        // Clocks per bit in simulation, 234 on a 27 MHz board

// Message buffer
`define MSG_DEPTH        8         // Byte slots in the buffer
`define CLEAR_CODE       8'h2F     // Command byte that empties the buffer

// Button
`define DEBOUNCE_CYCLES  32        // Stable clocks before a level counts

// RGB status codes
`define RGB_IDLE         3'b000    // Nothing received yet
`define RGB_STORED       3'b101    // Last byte went into the buffer
`define RGB_CLEARED      3'b011    // Buffer emptied by clear command
`define RGB_FULL         3'b110    // Last byte dropped on a full buffer

`endif
